//--- Makefile
# Verilator build and run for the AHB matrix output stage

VERILATOR ?= verilator
TOP       := tb_ahb_mtx_output_stage
FLIST     := flist.f
VFLAGS    := --binary --timing --assert -j 0
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
PASS_MSG  := No errors

SOURCES   := $(shell cat $(FLIST))

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- ahb_mtx_addr_mux.sv
// Address/control mux for the output stage
// Passes the granted port's address phase to the slave and
// decodes the one-hot active vector back to the input stages

`timescale 1ns/1ps

module ahb_mtx_addr_mux (
  input  ahb_mtx_pkg::ahb_addr_ctrl_t  i_port_ac [ahb_mtx_pkg::NUM_PORTS],
  input  ahb_mtx_pkg::port_idx_t       i_grant_port,  // Granted port
  input  logic                         i_no_port,     // No port granted
  output ahb_mtx_pkg::ahb_addr_ctrl_t  o_sel_ac,      // Muxed address phase
  output ahb_mtx_pkg::port_vec_t       o_active       // One-hot active
);

  import ahb_mtx_pkg::*;

  // ------------------------------------------------------------
  // Address and control select
  // ------------------------------------------------------------
  always_comb
  begin
    if (i_no_port)
      o_sel_ac = '0;                        // HSEL low, HTRANS IDLE
    else
      o_sel_ac = i_port_ac[i_grant_port];   // Whole struct in one go
  end

  // ------------------------------------------------------------
  // Active decode
  // ------------------------------------------------------------
  // Tells each input stage its address phase is on the slave bus
  always_comb
  begin
    o_active = '0;
    if (!i_no_port)
    begin
      for (int unsigned i = 0; i < NUM_PORTS; i++)
      begin
        if (i_grant_port == port_idx_t'(i))
          o_active[i] = 1'b1;               // Only the owner
      end
    end
  end

endmodule

//--- ahb_mtx_arbiter.sv
// Round-robin arbiter for the output stage
// Grant register searched from the port after the current owner.
// Holds during SEQ/BUSY and across a locked sequence, including
// cycles where the locked master addresses another slave

`timescale 1ns/1ps

module ahb_mtx_arbiter (
  input  logic                         HCLK,          // AHB clock
  input  logic                         HRESETn,       // Sync reset, active low
  input  ahb_mtx_pkg::ahb_addr_ctrl_t  i_port_ac [ahb_mtx_pkg::NUM_PORTS],
  input  ahb_mtx_pkg::port_vec_t       i_held_tran,   // Pending transfer per port
  input  ahb_mtx_pkg::ahb_addr_ctrl_t  i_sel_ac,      // Currently muxed address phase
  input  logic                         i_hreadymux,   // Address phase done
  output ahb_mtx_pkg::port_idx_t       o_grant_port,  // Granted port
  output logic                         o_no_port      // No port granted
);

  import ahb_mtx_pkg::*;

  port_vec_t req;          // Per port request
  port_idx_t grant_q;      // Grant register
  logic      no_port_q;    // Idle flag register
  port_idx_t next_port;    // Search winner
  logic      found;        // Search hit

  logic      hsel_lock_q;  // Locked sequence seen through this port
  logic      hsel_lock_d;
  logic      lock_arb;     // Masked HMASTLOCK
  logic      burst_cont;   // SEQ or BUSY on the muxed port
  logic      hold_grant;   // Keep current owner

  // ------------------------------------------------------------
  // Requests
  // ------------------------------------------------------------
  always_comb
  begin
    for (int unsigned i = 0; i < NUM_PORTS; i++)
    begin
      req[i] = i_held_tran[i] & i_port_ac[i].sel;  // Held tran gated by HSEL
    end
  end

  // ------------------------------------------------------------
  // Lock tracking
  // ------------------------------------------------------------
  // A locked master may briefly drop HSEL to reach another slave;
  // the lock register keeps the sequence alive until HMASTLOCK falls
  always_comb
  begin
    if (i_sel_ac.sel && i_sel_ac.trans[1] && i_sel_ac.mastlock)
      hsel_lock_d = 1'b1;                   // NONSEQ/SEQ locked to us
    else if (!i_sel_ac.mastlock)
      hsel_lock_d = 1'b0;                   // Sequence over
    else
      hsel_lock_d = hsel_lock_q;            // Keep through deselect
  end

  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      hsel_lock_q <= 1'b0;
    else if (i_hreadymux)
      hsel_lock_q <= hsel_lock_d;           // Frozen under wait states
  end

  assign lock_arb   = i_sel_ac.mastlock & (hsel_lock_q | i_sel_ac.sel);
  assign burst_cont = (i_sel_ac.trans == TRANS_SEQ) || (i_sel_ac.trans == TRANS_BUSY);
  assign hold_grant = ~no_port_q & (burst_cont | lock_arb);

  // ------------------------------------------------------------
  // Round-robin search
  // ------------------------------------------------------------
  always_comb
  begin : p_rr_search
    port_idx_t cand;                        // Port under test
    next_port = grant_q;
    found     = 1'b0;
    cand      = grant_q;
    // Start one past the owner, current owner checked last
    for (int unsigned off = 1; off <= NUM_PORTS; off++)
    begin
      cand = port_idx_t'(grant_q + off);    // Wraps at NUM_PORTS
      if (!found && req[cand])
      begin
        next_port = cand;
        found     = 1'b1;
      end
    end
  end

  // ------------------------------------------------------------
  // Grant register
  // ------------------------------------------------------------
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
    begin
      grant_q   <= '0;
      no_port_q <= 1'b1;                    // Idle out of reset
    end
    else if (i_hreadymux && !hold_grant)
    begin
      no_port_q <= ~found;
      if (found)
        grant_q <= next_port;               // Last index kept when idle
    end
  end

  assign o_grant_port = grant_q;
  assign o_no_port    = no_port_q;

endmodule

//--- ahb_mtx_data_phase.sv
// Data phase logic for the output stage
// Remembers which port owned the last completed address phase,
// steers its write data to the slave and forms HREADYMUX
// from the slave HREADYOUT when the slave was selected

`timescale 1ns/1ps

module ahb_mtx_data_phase (
  input  logic                    HCLK,          // AHB clock
  input  logic                    HRESETn,       // Sync reset, active low
  input  ahb_mtx_pkg::hwdata_t    i_port_wdata [ahb_mtx_pkg::NUM_PORTS],
  input  ahb_mtx_pkg::port_idx_t  i_grant_port,  // Address phase owner
  input  logic                    i_sel,         // Muxed HSEL
  input  logic                    i_hreadyout,   // Slave HREADYOUT
  output ahb_mtx_pkg::hwdata_t    o_hwdata,      // Write data to slave
  output logic                    o_hreadymux    // Transfer done
);

  import ahb_mtx_pkg::*;

  port_idx_t data_port_q;   // Data phase owner
  logic      slave_sel_q;   // Slave in data phase

  // ------------------------------------------------------------
  // Data phase registers
  // ------------------------------------------------------------
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
    begin
      data_port_q <= '0;
      slave_sel_q <= 1'b0;                  // HREADYMUX high after reset
    end
    else if (o_hreadymux)
    begin
      data_port_q <= i_grant_port;          // Address phase becomes data phase
      slave_sel_q <= i_sel;
    end
  end

  // ------------------------------------------------------------
  // Write data and ready mux
  // ------------------------------------------------------------
  assign o_hwdata = i_port_wdata[data_port_q];  // Held across wait states

  // Unselected data phases complete at once
  assign o_hreadymux = slave_sel_q ? i_hreadyout : 1'b1;

endmodule

//--- ahb_mtx_output_stage.sv
// AHB bus matrix output stage
// Routes one of four input stages to the shared slave.
// Round-robin arbiter, address/control mux and data phase write/ready mux

`timescale 1ns/1ps

module ahb_mtx_output_stage (
  input  logic                                 HCLK,         // AHB clock
  input  logic                                 HRESETn,      // Sync reset, active low
  input  ahb_mtx_pkg::ahb_addr_ctrl_t          i_port_ac    [ahb_mtx_pkg::NUM_PORTS],
  input  ahb_mtx_pkg::hwdata_t                 i_port_wdata [ahb_mtx_pkg::NUM_PORTS],
  input  ahb_mtx_pkg::port_vec_t               i_held_tran,  // Pending transfer per port
  input  logic                                 i_hreadyout,  // Slave HREADYOUT
  output ahb_mtx_pkg::port_vec_t               o_active,     // One-hot granted port
  output ahb_mtx_pkg::ahb_addr_ctrl_t          o_slave_ac,   // Address phase to slave
  output ahb_mtx_pkg::hwdata_t                 o_hwdata,     // Write data to slave
  output logic                                 o_hreadymux   // HREADY to slave and inputs
);

  import ahb_mtx_pkg::*;

  // ------------------------------------------------------------
  // Arbiter to mux interconnect
  // ------------------------------------------------------------
  port_idx_t grant_port;   // Address phase owner
  logic      no_port;      // Nobody granted

  ahb_mtx_arbiter u_arbiter (
    .HCLK         (HCLK),
    .HRESETn      (HRESETn),
    .i_port_ac    (i_port_ac),
    .i_held_tran  (i_held_tran),
    .i_sel_ac     (o_slave_ac),    // Muxed struct drives hold and lock
    .i_hreadymux  (o_hreadymux),
    .o_grant_port (grant_port),
    .o_no_port    (no_port)
  );

  ahb_mtx_addr_mux u_addr_mux (
    .i_port_ac    (i_port_ac),
    .i_grant_port (grant_port),
    .i_no_port    (no_port),
    .o_sel_ac     (o_slave_ac),
    .o_active     (o_active)
  );

  // Data phase follows the address phase by one ready edge
  ahb_mtx_data_phase u_data_phase (
    .HCLK         (HCLK),
    .HRESETn      (HRESETn),
    .i_port_wdata (i_port_wdata),
    .i_grant_port (grant_port),
    .i_sel        (o_slave_ac.sel),
    .i_hreadyout  (i_hreadyout),
    .o_hwdata     (o_hwdata),
    .o_hreadymux  (o_hreadymux)
  );

endmodule

//--- ahb_mtx_pkg.sv
// AHB bus matrix output stage shared definitions
// Bus widths, port count, HTRANS codes and the address phase struct
// used by the arbiter, address mux and data phase logic

package ahb_mtx_pkg;

  // ------------------------------------------------------------
  // Sizes
  // ------------------------------------------------------------
  localparam int unsigned NUM_PORTS = 4;                  // Input stages on this slave
  localparam int unsigned PORT_W    = $clog2(NUM_PORTS);  // Port index width
  localparam int unsigned ADDR_W    = 32;                 // HADDR width
  localparam int unsigned DATA_W    = 32;                 // HWDATA width

  localparam int unsigned TRANS_W   = 2;                  // HTRANS width
  localparam int unsigned SIZE_W    = 3;                  // HSIZE width
  localparam int unsigned BURST_W   = 3;                  // HBURST width
  localparam int unsigned PROT_W    = 4;                  // HPROT width
  localparam int unsigned MASTER_W  = 4;                  // HMASTER width

  // ------------------------------------------------------------
  // HTRANS encodings
  // ------------------------------------------------------------
  localparam logic [TRANS_W-1:0] TRANS_IDLE   = 2'b00;   // No transfer
  localparam logic [TRANS_W-1:0] TRANS_BUSY   = 2'b01;   // Burst pause
  localparam logic [TRANS_W-1:0] TRANS_NONSEQ = 2'b10;   // First beat
  localparam logic [TRANS_W-1:0] TRANS_SEQ    = 2'b11;   // Burst continuation

  // ------------------------------------------------------------
  // Types
  // ------------------------------------------------------------
  typedef logic [PORT_W-1:0]    port_idx_t;   // Port number
  typedef logic [NUM_PORTS-1:0] port_vec_t;   // One bit per port
  typedef logic [DATA_W-1:0]    hwdata_t;     // Write data word

  // One port's address phase, 51 bits
  typedef struct packed {
    logic                sel;       // HSEL
    logic [ADDR_W-1:0]   addr;      // HADDR
    logic [TRANS_W-1:0]  trans;     // HTRANS
    logic                write;     // HWRITE
    logic [SIZE_W-1:0]   size;      // HSIZE
    logic [BURST_W-1:0]  burst;     // HBURST
    logic [PROT_W-1:0]   prot;      // HPROT
    logic [MASTER_W-1:0] master;    // HMASTER
    logic                mastlock;  // HMASTLOCK
  } ahb_addr_ctrl_t;

endpackage

//--- ahb_mtx_properties.sv
// Concurrent checks on the AHB output stage
// One-hot active, slave select ownership, wait state freeze
// and ready level right after reset

`timescale 1ns/1ps

module ahb_mtx_properties (
  input logic                         HCLK,         // AHB clock
  input logic                         HRESETn,      // Sync reset, active low
  input ahb_mtx_pkg::port_vec_t       i_active,     // One-hot granted port
  input ahb_mtx_pkg::ahb_addr_ctrl_t  i_slave_ac,   // Address phase to slave
  input logic                         i_hreadymux   // HREADY to slave
);

  // ------------------------------------------------------------
  // Grant shape
  // ------------------------------------------------------------
  a_active_onehot : assert property (@(posedge HCLK) disable iff (!HRESETn)
    $onehot0(i_active))
    else $error("o_active has more than one bit set: %b", i_active);

  // HSEL to the slave needs an owner
  a_sel_has_owner : assert property (@(posedge HCLK) disable iff (!HRESETn)
    i_slave_ac.sel |-> (i_active != '0))
    else $error("o_slave_ac.sel high with no active port");

  // ------------------------------------------------------------
  // Handshake
  // ------------------------------------------------------------
  a_wait_freezes_grant : assert property (@(posedge HCLK) disable iff (!HRESETn)
    !i_hreadymux |=> $stable(i_active))
    else $error("o_active changed during a wait state");

  a_ready_after_reset : assert property (@(posedge HCLK)
    $rose(HRESETn) |-> i_hreadymux)
    else $error("o_hreadymux low in the first cycle after reset");

endmodule

bind ahb_mtx_output_stage ahb_mtx_properties u_properties (
  .HCLK        (HCLK),
  .HRESETn     (HRESETn),
  .i_active    (o_active),
  .i_slave_ac  (o_slave_ac),
  .i_hreadymux (o_hreadymux)
);

//--- flist.f
ahb_mtx_pkg.sv
ahb_mtx_arbiter.sv
ahb_mtx_addr_mux.sv
ahb_mtx_data_phase.sv
ahb_mtx_output_stage.sv
ahb_mtx_properties.sv
tb_ahb_mtx_output_stage.sv

//--- tb_ahb_mtx_output_stage.sv
// Directed testbench for the AHB bus matrix output stage
// Covers reset, single request, round-robin order, burst hold,
// locked sequences and data phase wait states

`timescale 1ns/1ps

module tb_ahb_mtx_output_stage;

  import ahb_mtx_pkg::*;

  localparam int CLK_PERIOD      = 20;    // 50 MHz HCLK
  localparam int NUM_TESTS       = 6;
  localparam int CYCLES_PER_TEST = 200;   // Generous upper bound per test
  localparam int WATCHDOG_NS     = NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD;

  logic           HCLK;
  logic           HRESETn;
  ahb_addr_ctrl_t port_ac    [NUM_PORTS];  // Per port address phase
  hwdata_t        port_wdata [NUM_PORTS];  // Per port write data
  port_vec_t      held_tran;
  logic           hreadyout;
  port_vec_t      active;
  ahb_addr_ctrl_t slave_ac;
  hwdata_t        hwdata;
  logic           hreadymux;

  integer seed;            // $random state
  int     error_count;     // All mismatches
  int     test_errors;     // Mismatches in current test
  int     tests_run;
  int     tests_failed;
  string  test_name;

  ahb_mtx_output_stage uut (
    .HCLK         (HCLK),
    .HRESETn      (HRESETn),
    .i_port_ac    (port_ac),
    .i_port_wdata (port_wdata),
    .i_held_tran  (held_tran),
    .i_hreadyout  (hreadyout),
    .o_active     (active),
    .o_slave_ac   (slave_ac),
    .o_hwdata     (hwdata),
    .o_hreadymux  (hreadymux)
  );

  always #(CLK_PERIOD / 2) HCLK = ~HCLK;

  // ------------------------------------------------------------
  // Stimulus helpers
  // ------------------------------------------------------------
  task automatic apply_reset();
    @(negedge HCLK);
    HRESETn = 1'b0;
    repeat (4) @(negedge HCLK);            // Four rising edges in reset
    HRESETn = 1'b1;
  endtask

  // One rising edge and back to the drive/sample point
  task automatic cycle();
    @(posedge HCLK);
    @(negedge HCLK);
  endtask

  task automatic clear_ports();
    for (int i = 0; i < NUM_PORTS; i++)
    begin
      port_ac[i]    = '0;
      port_wdata[i] = '0;
    end
    held_tran = '0;
    hreadyout = 1'b1;                      // Slave always ready by default
  endtask

  function automatic ahb_addr_ctrl_t make_ac(logic [TRANS_W-1:0] trans, logic sel,
                                             logic lock, logic [MASTER_W-1:0] master);
    ahb_addr_ctrl_t ac;
    logic [31:0]    rnd;
    ac          = '0;
    rnd         = $random(seed);
    ac.addr     = $random(seed);
    ac.sel      = sel;
    ac.trans    = trans;
    ac.write    = rnd[7];
    ac.size     = 3'b010;                  // Word transfers
    ac.burst    = rnd[2:0];
    ac.prot     = rnd[6:3];
    ac.master   = master;
    ac.mastlock = lock;
    return ac;
  endfunction

  // ------------------------------------------------------------
  // Expected value helpers
  // ------------------------------------------------------------
  function automatic port_vec_t port_bit(port_idx_t idx);
    port_vec_t v;
    v      = '0;
    v[idx] = 1'b1;
    return v;
  endfunction

  // A port requests when it holds a transfer and selects this slave
  function automatic port_vec_t request_vec();
    port_vec_t r;
    for (int i = 0; i < NUM_PORTS; i++)
      r[i] = held_tran[i] & port_ac[i].sel;
    return r;
  endfunction

  // Walk upward from the owner and wrap with the owner itself last
  function automatic port_idx_t next_rr_owner(port_idx_t cur, port_vec_t reqs);
    port_idx_t idx;
    port_idx_t pick;
    logic      hit;
    idx  = cur;
    pick = cur;                            // Nobody asking keeps the index
    hit  = 1'b0;
    repeat (NUM_PORTS)
    begin
      idx = idx + 1'b1;
      if (!hit && reqs[idx])
      begin
        pick = idx;
        hit  = 1'b1;
      end
    end
    return pick;
  endfunction

  // ------------------------------------------------------------
  // Compare tasks
  // ------------------------------------------------------------
  task automatic compare_ac(string what, ahb_addr_ctrl_t exp, ahb_addr_ctrl_t act);
    if (act !== exp)
    begin
      $display("[FAIL] %s %s: expected %h actual %h", test_name, what, exp, act);
      test_errors++;
      error_count++;
    end
  endtask

  task automatic compare_vec(string what, port_vec_t exp, port_vec_t act);
    if (act !== exp)
    begin
      $display("[FAIL] %s %s: expected %b actual %b", test_name, what, exp, act);
      test_errors++;
      error_count++;
    end
  endtask

  task automatic compare_data(string what, hwdata_t exp, hwdata_t act);
    if (act !== exp)
    begin
      $display("[FAIL] %s %s: expected %h actual %h", test_name, what, exp, act);
      test_errors++;
      error_count++;
    end
  endtask

  task automatic compare_bit(string what, logic exp, logic act);
    if (act !== exp)
    begin
      $display("[FAIL] %s %s: expected %b actual %b", test_name, what, exp, act);
      test_errors++;
      error_count++;
    end
  endtask

  task automatic begin_test(string name);
    test_name   = name;
    test_errors = 0;
    tests_run++;
  endtask

  task automatic end_test();
    if (test_errors == 0)
      $display("Test %s: passed", test_name);
    else
    begin
      $display("Test %s: %0d mismatches", test_name, test_errors);
      tests_failed++;
    end
  endtask

  // ------------------------------------------------------------
  // Tests
  // ------------------------------------------------------------
  task automatic test_reset_state();
    begin_test("reset_state");
    clear_ports();
    for (int i = 0; i < NUM_PORTS; i++)
      port_ac[i] = make_ac(TRANS_NONSEQ, 1'b1, 1'b0, MASTER_W'(i));
    held_tran = '1;                        // Requests must not leak through reset
    hreadyout = 1'b0;                      // Ready mux must not follow the slave
    apply_reset();
    compare_vec("o_active", '0, active);
    compare_ac("o_slave_ac", '0, slave_ac);   // HSEL low and HTRANS IDLE
    compare_bit("o_hreadymux", 1'b1, hreadymux);
    end_test();
  endtask

  task automatic test_single_request();
    ahb_addr_ctrl_t exp_ac;
    begin_test("single_request");
    clear_ports();
    apply_reset();
    exp_ac       = make_ac(TRANS_NONSEQ, 1'b1, 1'b0, 4'd2);
    port_ac[2]   = exp_ac;
    held_tran[2] = 1'b1;
    cycle();
    compare_vec("o_active", port_bit(2'd2), active);
    compare_ac("o_slave_ac", exp_ac, slave_ac);
    end_test();
  endtask

  task automatic test_round_robin();
    port_idx_t exp_owner;
    begin_test("round_robin");
    clear_ports();
    for (int i = 0; i < NUM_PORTS; i++)
      port_ac[i] = make_ac(TRANS_NONSEQ, 1'b1, 1'b0, MASTER_W'(i));
    held_tran = '1;                        // Everyone asks from reset
    apply_reset();
    exp_owner = '0;                        // Search starts after the reset index
    repeat (9)
    begin
      exp_owner = next_rr_owner(exp_owner, request_vec());
      cycle();
      compare_vec("o_active", port_bit(exp_owner), active);
      compare_ac("o_slave_ac", port_ac[exp_owner], slave_ac);
    end
    end_test();
  endtask

  task automatic test_burst_hold();
    port_idx_t exp_owner;
    begin_test("burst_hold");
    clear_ports();
    apply_reset();
    port_ac[1]   = make_ac(TRANS_NONSEQ, 1'b1, 1'b0, 4'd1);
    held_tran[1] = 1'b1;
    cycle();                               // Port 1 wins the first beat
    compare_vec("o_active first beat", port_bit(2'd1), active);
    port_ac[0] = make_ac(TRANS_NONSEQ, 1'b1, 1'b0, 4'd0);
    port_ac[3] = make_ac(TRANS_NONSEQ, 1'b1, 1'b0, 4'd3);
    held_tran  = 4'b1011;
    for (int beat = 0; beat < 4; beat++)
    begin
      port_ac[1].trans = (beat == 2) ? TRANS_BUSY : TRANS_SEQ;
      port_ac[1].addr  = port_ac[1].addr + 32'd4;
      cycle();
      compare_vec("o_active in burst", port_bit(2'd1), active);
      compare_ac("o_slave_ac in burst", port_ac[1], slave_ac);
    end
    // Grant moves on once the burst ends
    port_ac[1].trans = TRANS_IDLE;
    held_tran[1]     = 1'b0;
    exp_owner        = next_rr_owner(2'd1, request_vec());
    cycle();
    compare_vec("o_active after burst", port_bit(exp_owner), active);
    compare_ac("o_slave_ac after burst", port_ac[exp_owner], slave_ac);
    end_test();
  endtask

  task automatic test_locked_sequence();
    port_idx_t exp_owner;
    begin_test("locked_sequence");
    clear_ports();
    apply_reset();
    port_ac[0]   = make_ac(TRANS_NONSEQ, 1'b1, 1'b1, 4'd0);
    held_tran[0] = 1'b1;
    cycle();
    compare_vec("o_active lock start", port_bit(2'd0), active);
    // Port 2 starts competing on the second locked beat
    port_ac[0]   = make_ac(TRANS_NONSEQ, 1'b1, 1'b1, 4'd0);
    port_ac[2]   = make_ac(TRANS_NONSEQ, 1'b1, 1'b0, 4'd2);
    held_tran[2] = 1'b1;
    cycle();
    compare_vec("o_active locked beat", port_bit(2'd0), active);
    // Locked master visits another slave
    port_ac[0].sel = 1'b0;
    held_tran[0]   = 1'b0;
    cycle();
    compare_vec("o_active deselected", port_bit(2'd0), active);
    compare_ac("o_slave_ac deselected", port_ac[0], slave_ac);
    // Lock released when HMASTLOCK falls
    port_ac[0].mastlock = 1'b0;
    port_ac[0].trans    = TRANS_IDLE;
    exp_owner           = next_rr_owner(2'd0, request_vec());
    cycle();
    compare_vec("o_active unlocked", port_bit(exp_owner), active);
    end_test();
  endtask

  task automatic test_data_phase();
    port_idx_t owner;
    port_idx_t data_owner;
    begin_test("data_phase");
    clear_ports();
    apply_reset();
    for (int i = 0; i < NUM_PORTS; i++)
      port_wdata[i] = $random(seed);
    port_ac[1]       = make_ac(TRANS_NONSEQ, 1'b1, 1'b0, 4'd1);
    port_ac[1].write = 1'b1;
    held_tran[1]     = 1'b1;
    cycle();                               // Port 1 address phase on the bus
    compare_vec("o_active addr phase", port_bit(2'd1), active);
    port_ac[3]       = make_ac(TRANS_NONSEQ, 1'b1, 1'b0, 4'd3);
    port_ac[3].write = 1'b1;
    held_tran[3]     = 1'b1;
    data_owner       = 2'd1;
    owner            = next_rr_owner(2'd1, request_vec());
    cycle();
    compare_vec("o_active next owner", port_bit(owner), active);
    compare_data("o_hwdata", port_wdata[data_owner], hwdata);
    compare_bit("o_hreadymux ready", 1'b1, hreadymux);
    hreadyout = 1'b0;                      // Slave inserts wait states
    repeat (3)
    begin
      cycle();
      compare_bit("o_hreadymux wait", 1'b0, hreadymux);
      compare_vec("o_active wait", port_bit(owner), active);
      compare_ac("o_slave_ac wait", port_ac[owner], slave_ac);
      compare_data("o_hwdata wait", port_wdata[data_owner], hwdata);
    end
    hreadyout  = 1'b1;
    data_owner = owner;
    owner      = next_rr_owner(owner, request_vec());
    cycle();
    compare_bit("o_hreadymux release", 1'b1, hreadymux);
    compare_vec("o_active release", port_bit(owner), active);
    compare_data("o_hwdata release", port_wdata[data_owner], hwdata);
    end_test();
  endtask

  // ------------------------------------------------------------
  // Main sequence and watchdog
  // ------------------------------------------------------------
  initial
  begin
    HCLK         = 1'b0;
    HRESETn      = 1'b0;
    seed         = 32'h2e47;
    error_count  = 0;
    tests_run    = 0;
    tests_failed = 0;
    clear_ports();

    test_reset_state();
    test_single_request();
    test_round_robin();
    test_burst_hold();
    test_locked_sequence();
    test_data_phase();

    $display("Tests run %0d, tests failed %0d, mismatches %0d",
             tests_run, tests_failed, error_count);
    if (error_count == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

  initial
  begin
    #(WATCHDOG_NS);
    $display("Timeout: tests did not finish within %0d ns", WATCHDOG_NS);
    $display("Errors found");
    $finish;
  end

endmodule
